// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rsa256
FILELIST  ?= rsa256.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard hw/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# $fatal in the testbench gives a nonzero exit status
run: compile
	./$(SIM) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_rsa_ref.svh ====
`ifndef TB_RSA_REF_SVH
`define TB_RSA_REF_SVH

// 32-bit xorshift step with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// a*b mod n, scanning b from the top bit down; a must be below n
function automatic word_t ref_mod_mul(input word_t a, input word_t b, input word_t n);
    logic [WORD_W:0] r;
    logic [WORD_W:0] n_ext;
    r     = '0;
    n_ext = {1'b0, n};
    for (int i = WORD_W - 1; i >= 0; i--) begin
        r = r << 1;
        if (r >= n_ext) begin
            r = r - n_ext;
        end
        if (b[i]) begin
            r = r + {1'b0, a};
        end
        if (r >= n_ext) begin
            r = r - n_ext;  // back below n
        end
    end
    return r[WORD_W-1:0];
endfunction

// right-to-left square and multiply, x below n
function automatic word_t ref_mod_exp(input word_t x, input word_t d, input word_t n);
    word_t result;
    word_t base;
    result = word_t'(1);
    base   = x;
    for (int i = 0; i < WORD_W; i++) begin
        if (d[i]) begin
            result = ref_mod_mul(result, base, n);
        end
        base = ref_mod_mul(base, base, n);
    end
    return result;
endfunction

`endif

// ==== bench/tb_rsa256.sv ====
`timescale 1ns/1ps

module tb_rsa256;
    import rsa_pkg::*;

    `include "tb_rsa_ref.svh"

    localparam int TIMEOUT = 400000;

    logic     i_clk;
    logic     i_rst;
    logic     i_start;
    rsa_req_t i_req;
    word_t    o_result;
    logic     o_done;

    logic [31:0] rng;
    word_t       exp_q[$];   // expected results in start order
    string       name_q[$];
    int          n_started = 0;
    int          n_checked = 0;
    logic        done_prev;

    rsa256_top DUT (.*);

    always #5 i_clk = ~i_clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected o_done %b actual o_done %b",
                                name, expected, actual));
        end
    endtask

    // compares each result on the rising edge of o_done
    always @(posedge i_clk) begin
        if (i_rst) begin
            done_prev <= 1'b0;
        end else begin
            done_prev <= o_done;
            if (o_done && !done_prev) begin
                if (exp_q.size() == 0) begin
                    abort_run("o_done rose although no run was pending");
                end else begin
                    check_word(name_q.pop_front(), exp_q.pop_front(), o_result);
                    n_checked <= n_checked + 1;
                end
            end
        end
    end

    task automatic random_word(output word_t w);
        for (int i = 0; i < WORD_W / 32; i++) begin
            rng = xorshift32(rng);
            w[i*32 +: 32] = rng;
        end
    endtask

    // odd modulus with the top bit set, message below it
    task automatic random_req(output rsa_req_t req);
        random_word(req.n);
        random_word(req.x);
        random_word(req.d);
        req.n[WORD_W-1] = 1'b1;
        req.n[0]        = 1'b1;
        if (req.x >= req.n) begin
            req.x = req.x - req.n;
        end
    endtask

    // called right after a rising edge
    task automatic start_run(input string name, input rsa_req_t req, input word_t expected);
        i_req   <= req;
        i_start <= 1'b1;
        exp_q.push_back(expected);
        name_q.push_back(name);
        n_started++;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(posedge i_clk);
        check_done({name, " after start"}, 1'b0, o_done);
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        while (n_checked < n_started && cycles < TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (n_checked < n_started) begin
            abort_run($sformatf("timeout: o_done did not rise during %s", name));
        end
    endtask

    // returns at the first edge that sees o_done high
    task automatic wait_done_high(input string name);
        int cycles;
        cycles = 0;
        while (!o_done && cycles < TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (!o_done) begin
            abort_run($sformatf("timeout: o_done did not rise during %s", name));
        end
    endtask

    task automatic run_case(input string name, input rsa_req_t req);
        start_run(name, req, ref_mod_exp(req.x, req.d, req.n));
        wait_done(name);
    endtask

    initial begin
        rsa_req_t req;
        rsa_req_t other;
        i_clk   = 1'b0;
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_req   = '0;
        rng     = 32'h0e7e_25e1;
        repeat (3) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        check_done("idle after reset", 1'b0, o_done);

        random_req(req);
        req.d = '0;
        start_run("exp_zero", req, word_t'(1));
        wait_done("exp_zero");
        req.d = word_t'(1);
        start_run("exp_one", req, req.x);
        wait_done("exp_one");

        req.x      = '0;
        req.d[200] = 1'b1;
        start_run("zero_message", req, '0);
        wait_done("zero_message");

        for (int i = 0; i < 4; i++) begin
            random_req(req);
            run_case($sformatf("random_%0d", i), req);
        end

        // request changes and a second start arrive while busy
        random_req(req);
        random_req(other);
        start_run("busy_start", req, ref_mod_exp(req.x, req.d, req.n));
        i_req <= other;
        repeat (100) @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        wait_done("busy_start");

        // next start goes out on the edge that first sees o_done high
        random_req(req);
        start_run("back_to_back_0", req, ref_mod_exp(req.x, req.d, req.n));
        wait_done_high("back_to_back_0");
        random_req(req);
        run_case("back_to_back_1", req);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== hw/mod_prep.sv ====
`timescale 1ns/1ps

module mod_prep (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_x,
    output rsa_pkg::word_t o_xr,
    output logic           o_ready
);
    import rsa_pkg::*;

    logic  busy_q;
    logic  ready_q;
    cnt_t  cnt_q;
    word_t val_q;
    acc_t  dbl;
    acc_t  red;

    assign dbl = {1'b0, val_q, 1'b0};  // 2 * val, below 2N
    assign red = (dbl >= acc_t'(i_n)) ? dbl - acc_t'(i_n) : dbl;

    assign o_xr    = val_q;
    assign o_ready = ready_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            busy_q  <= 1'b0;
            ready_q <= 1'b0;
            cnt_q   <= '0;
        end else if (!busy_q) begin
            if (i_start) begin
                busy_q  <= 1'b1;
                ready_q <= 1'b0;
                cnt_q   <= '0;
            end
        end else begin
            cnt_q <= cnt_q + cnt_t'(1);
            if (cnt_q == LAST_BIT) begin  // 256th doubling
                busy_q  <= 1'b0;
                ready_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy_q && i_start) begin
            val_q <= i_x;
        end else if (busy_q) begin
            val_q <= red[WORD_W-1:0];
        end
    end

    // x below N on entry, and each reduced doubling stays below N
    a_val_below_n: assert property (@(posedge i_clk) disable iff (i_rst)
        busy_q |-> (val_q < i_n))
        else $error("mod_prep: running value not below N");

endmodule

// ==== hw/mont_mult.sv ====
`timescale 1ns/1ps

module mont_mult (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_a,
    input  rsa_pkg::word_t i_b,
    output rsa_pkg::word_t o_m,
    output logic           o_ready
);
    import rsa_pkg::*;

    mont_state_e state_q, state_d;
    acc_t        acc_q, acc_d;
    cnt_t        cnt_q, cnt_d;
    logic        ready_q, ready_d;
    acc_t        n_ext;

    // operands must stay stable until o_ready returns
    assign n_ext   = acc_t'(i_n);
    assign o_m     = acc_q[WORD_W-1:0];  // below N after the last reduce
    assign o_ready = ready_q;

    always_comb begin
        state_d = state_q;
        acc_d   = acc_q;
        cnt_d   = cnt_q;
        ready_d = ready_q;
        unique case (state_q)
            MONT_IDLE: begin
                if (i_start) begin  // load cycle
                    acc_d   = '0;
                    cnt_d   = '0;
                    ready_d = 1'b0;
                    state_d = MONT_ADD;
                end
            end
            MONT_ADD: begin
                if (i_a[cnt_q[7:0]]) begin
                    acc_d = acc_q + acc_t'(i_b);
                end
                state_d = MONT_HALVE;
            end
            MONT_HALVE: begin
                if (acc_q[0]) begin
                    acc_d = (acc_q + n_ext) >> 1;  // make even before the shift
                end else begin
                    acc_d = acc_q >> 1;
                end
                state_d = MONT_REDUCE;
            end
            MONT_REDUCE: begin
                if (acc_q >= n_ext) begin
                    acc_d = acc_q - n_ext;
                end
                if (cnt_q == LAST_BIT) begin
                    ready_d = 1'b1;
                    state_d = MONT_IDLE;
                end else begin
                    cnt_d   = cnt_q + cnt_t'(1);
                    state_d = MONT_ADD;
                end
            end
            default: begin
                state_d = MONT_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q <= MONT_IDLE;
            cnt_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            ready_q <= ready_d;
        end
    end

    always_ff @(posedge i_clk) begin
        acc_q <= acc_d;
    end

    // halving keeps the sum below 2N, so one subtraction is enough
    a_acc_below_2n: assert property (@(posedge i_clk) disable iff (i_rst)
        (state_q == MONT_REDUCE) |-> (acc_q < (n_ext << 1)))
        else $error("mont_mult: accumulator not below 2N after halve");

    a_ready_idle: assert property (@(posedge i_clk) disable iff (i_rst)
        (state_q != MONT_IDLE) |-> !o_ready)
        else $error("mont_mult: ready high during a multiplication");

endmodule

// ==== hw/rsa256_top.sv ====
`timescale 1ns/1ps

module rsa256_top (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  rsa_pkg::rsa_req_t i_req,
    output rsa_pkg::word_t    o_result,
    output logic              o_done
);
    import rsa_pkg::*;

    logic  prep_start, sq_start, acc_start;
    logic  prep_ready, sq_ready, acc_ready;
    word_t n, x, sq, acc;
    word_t prep_xr, sq_m, acc_m;

    rsa_exp_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start      (i_start),
        .i_req        (i_req),
        .o_prep_start (prep_start),
        .o_mult_start (sq_start),
        .o_acc_start  (acc_start),
        .o_n          (n),
        .o_x          (x),
        .o_sq         (sq),
        .o_acc        (acc),
        .i_prep_ready (prep_ready),
        .i_sq_ready   (sq_ready),
        .i_acc_ready  (acc_ready),
        .i_prep_xr    (prep_xr),
        .i_sq_m       (sq_m),
        .i_acc_m      (acc_m),
        .o_result     (o_result),
        .o_done       (o_done)
    );

    mod_prep u_prep (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (prep_start),
        .i_n     (n),
        .i_x     (x),
        .o_xr    (prep_xr),
        .o_ready (prep_ready)
    );

    // power squared in place
    mont_mult u_mult_sq (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (sq_start),
        .i_n     (n),
        .i_a     (sq),
        .i_b     (sq),
        .o_m     (sq_m),
        .o_ready (sq_ready)
    );

    mont_mult u_mult_acc (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_start (acc_start),
        .i_n     (n),
        .i_a     (acc),
        .i_b     (sq),
        .o_m     (acc_m),
        .o_ready (acc_ready)
    );

endmodule

// ==== hw/rsa_exp_ctrl.sv ====
`timescale 1ns/1ps

module rsa_exp_ctrl (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_start,
    input  rsa_pkg::rsa_req_t i_req,
    output logic              o_prep_start,
    output logic              o_mult_start,
    output logic              o_acc_start,
    output rsa_pkg::word_t    o_n,
    output rsa_pkg::word_t    o_x,
    output rsa_pkg::word_t    o_sq,
    output rsa_pkg::word_t    o_acc,
    input  logic              i_prep_ready,
    input  logic              i_sq_ready,
    input  logic              i_acc_ready,
    input  rsa_pkg::word_t    i_prep_xr,
    input  rsa_pkg::word_t    i_sq_m,
    input  rsa_pkg::word_t    i_acc_m,
    output rsa_pkg::word_t    o_result,
    output logic              o_done
);
    import rsa_pkg::*;

    exp_state_e state_q;
    rsa_req_t   req_q;
    word_t      pow_q;  // running power, Montgomery form
    word_t      acc_q;  // accumulated result, plain form
    cnt_t       bit_q;
    cnt_t       bit_nxt;
    logic       bit_set;
    logic       prep_start_q;
    logic       sq_start_q;
    logic       acc_start_q;
    logic       done_q;
    logic       step_done;

    assign bit_nxt = bit_q + cnt_t'(1);
    assign bit_set = req_q.d[bit_q[7:0]];

    // strobe cycle is skipped, ready still shows the previous run then
    assign step_done = !sq_start_q && i_sq_ready && (!bit_set || i_acc_ready);

    assign o_prep_start = prep_start_q;
    assign o_mult_start = sq_start_q;
    assign o_acc_start  = acc_start_q;
    assign o_n          = req_q.n;
    assign o_x          = req_q.x;
    assign o_sq         = pow_q;
    assign o_acc        = acc_q;
    assign o_result     = acc_q;
    assign o_done       = done_q;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q      <= EXP_IDLE;
            bit_q        <= '0;
            prep_start_q <= 1'b0;
            sq_start_q   <= 1'b0;
            acc_start_q  <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            prep_start_q <= 1'b0;
            sq_start_q   <= 1'b0;
            acc_start_q  <= 1'b0;
            unique case (state_q)
                EXP_IDLE: begin
                    if (i_start) begin
                        done_q       <= 1'b0;
                        prep_start_q <= 1'b1;
                        state_q      <= EXP_PREP;
                    end
                end
                EXP_PREP: begin
                    if (!prep_start_q && i_prep_ready) begin
                        state_q <= EXP_LOAD;
                    end
                end
                EXP_LOAD: begin
                    bit_q       <= '0;
                    sq_start_q  <= 1'b1;
                    acc_start_q <= req_q.d[0];
                    state_q     <= EXP_STEP;
                end
                EXP_STEP: begin
                    if (step_done) begin
                        if (bit_q == LAST_BIT) begin
                            state_q <= EXP_DONE;
                        end else begin
                            bit_q       <= bit_nxt;
                            sq_start_q  <= 1'b1;
                            acc_start_q <= req_q.d[bit_nxt[7:0]];
                        end
                    end
                end
                EXP_DONE: begin
                    done_q  <= 1'b1;
                    state_q <= EXP_IDLE;
                end
                default: begin
                    state_q <= EXP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == EXP_IDLE && i_start) begin
            req_q <= i_req;
        end
        if (state_q == EXP_LOAD) begin
            pow_q <= i_prep_xr;
            acc_q <= WORD_ONE;  // factors of R cancel against the power
        end else if (state_q == EXP_STEP && step_done) begin
            pow_q <= i_sq_m;
            if (bit_set) begin
                acc_q <= i_acc_m;
            end
        end
    end

    a_acc_with_sq: assert property (@(posedge i_clk) disable iff (i_rst)
        o_acc_start |-> o_mult_start)
        else $error("rsa_exp_ctrl: accumulator start without square start");

endmodule

// ==== hw/rsa_pkg.sv ====
package rsa_pkg;

    localparam int WORD_W = 256;
    localparam int ACC_W  = WORD_W + 2;  // holds 2N + 2^256 without overflow
    localparam int CNT_W  = 9;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    localparam cnt_t  LAST_BIT = cnt_t'(WORD_W - 1);
    localparam word_t WORD_ONE = word_t'(1);

    // request as driven by the host together with the start pulse
    typedef struct packed {
        word_t n;  // odd modulus
        word_t x;  // message, below n
        word_t d;  // exponent
    } rsa_req_t;

    typedef enum logic [1:0] {
        MONT_IDLE,
        MONT_ADD,
        MONT_HALVE,
        MONT_REDUCE
    } mont_state_e;

    typedef enum logic [2:0] {
        EXP_IDLE,
        EXP_PREP,
        EXP_LOAD,
        EXP_STEP,
        EXP_DONE
    } exp_state_e;

endpackage

// ==== rsa256.f ====
+incdir+bench
hw/rsa_pkg.sv
hw/mont_mult.sv
hw/mod_prep.sv
hw/rsa_exp_ctrl.sv
hw/rsa256_top.sv
bench/tb_rsa256.sv
